// ==== sim.f ====
logic/coreControlPkg.sv
logic/phaseSequencer.sv
logic/flagUnit.sv
logic/controlDecoder.sv
logic/busCycleGen.sv
logic/controlUnit.sv
verification/controlChecker.sv
verification/tbControlUnit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps -j 0 \
   --top-module tbControlUnit -f sim.f -o simControlUnit

./obj_dir/simControlUnit | tee sim.log

if grep -q "^Verification passed$" sim.log; then
   echo "simulation result: pass"
   exit 0
else
   echo "simulation result: FAIL, see sim.log"
   exit 1
fi

// ==== verification/tbControlUnit.sv ====
`default_nettype none

module tbControlUnit;

   timeunit 1ns;
   timeprecision 100ps;

   import coreControlPkg::*;

   localparam int fetchTimeout = 12; // longest instruction takes 9 cycles
   localparam int randomCount = 300;

   logic Clock;
   logic nReset;
   instrByte_t instr;
   flags_t flags;
   controlWord_t ctrl;
   memBus_t bus;
   int errorCount;
   int checkCount;
   integer seed;
   logic timedOut;

   controlUnit dut (
      .Clock  (Clock),
      .nReset (nReset),
      .instr  (instr),
      .flags  (flags),
      .ctrl   (ctrl),
      .bus    (bus)
   );

   controlChecker refCheck (
      .Clock      (Clock),
      .nReset     (nReset),
      .instr      (instr),
      .flags      (flags),
      .ctrl       (ctrl),
      .bus        (bus),
      .errorCount (errorCount),
      .checkCount (checkCount)
   );

   always #10 Clock = ~Clock;

   // Fet1 is the only phase with pcEn and ale together
   task automatic waitFetch();
      int cycles;
      cycles = 0;
      do begin
         @(negedge Clock);
         cycles++;
      end while (!(ctrl.pcEn && bus.ale) && cycles < fetchTimeout);
      if (!(ctrl.pcEn && bus.ale)) begin
         $display("Timeout at %0t ns: no new fetch within %0d cycles", $time, fetchTimeout);
         timedOut = 1'b1;
      end
   endtask

   task automatic runInstr(input opcode_t op, input branchCode_t cond, input flags_t f);
      if (!timedOut) begin
         instr.opcode = op;
         instr.cond = cond;
         flags = f;
         waitFetch(); // returns in the next Fet1
      end
   endtask

   function automatic flags_t randomFlags();
      logic [31:0] r;
      r = $random(seed);
      return flags_t'(r[2:0]);
   endfunction

   task automatic reportTest(input int num, input string name, input int errorsBefore);
      int found;
      found = errorCount - errorsBefore;
      if (timedOut) begin
         $display("test %0d %s: stopped by timeout", num, name);
      end else if (found == 0) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d errors", num, name, found);
      end
   endtask

   initial begin
      int mark;
      logic [31:0] r;
      logic [31:0] pick;
      Clock = 1'b0;
      nReset = 1'b0;
      instr = '{opcode: LLI, cond: BR};
      flags = '0;
      seed = 32'hd4bc;
      timedOut = 1'b0;
      repeat (16) @(negedge Clock);
      nReset = 1'b1; // still Fet1 until the next rising edge

      mark = errorCount;
      runInstr(LLI, BR, 3'b000);
      runInstr(LUI, BR, 3'b111);
      runInstr(BRANCH, BE, 3'b111); // status register still holds its reset value
      runInstr(BRANCH, BLT, 3'b111);
      reportTest(1, "reset and fetch", mark);

      mark = errorCount;
      for (int i = 0; i <= 13; i++) begin
         runInstr(opcode_t'(i[4:0]), BR, randomFlags());
      end
      reportTest(2, "ALU instructions", mark);

      mark = errorCount;
      runInstr(LDW, BR, randomFlags());
      runInstr(STW, BR, randomFlags());
      runInstr(LDW, BLT, randomFlags());
      runInstr(STW, JMP, randomFlags());
      reportTest(3, "loads and stores", mark);

      mark = errorCount;
      for (int code = 0; code < 5; code++) begin
         for (int f = 0; f < 8; f++) begin
            runInstr(CMP, BR, flags_t'(f[2:0])); // known status for the branch
            runInstr(BRANCH, branchCode_t'(code[2:0]), randomFlags());
         end
      end
      reportTest(4, "conditional branches", mark);

      mark = errorCount;
      runInstr(BRANCH, BWL, randomFlags());
      runInstr(BRANCH, RET, randomFlags());
      runInstr(BRANCH, JMP, randomFlags());
      reportTest(5, "link, return and jump", mark);

      mark = errorCount;
      for (int n = 0; n < randomCount; n++) begin
         r = $random(seed);
         pick = r % 32'd17;
         runInstr(opcode_t'(pick[4:0]), branchCode_t'(r[18:16]), randomFlags());
      end
      reportTest(6, "random stream", mark);

      $display("checks %0d, errors %0d", checkCount, errorCount);
      if (timedOut || errorCount != 0 || checkCount == 0) begin
         $display("Verification failed");
      end else begin
         $display("Verification passed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verification/controlChecker.sv ====
`default_nettype none

module controlChecker (
   input  wire                              Clock,
   input  wire                              nReset,
   input  wire coreControlPkg::instrByte_t   instr,
   input  wire coreControlPkg::flags_t       flags,
   input  wire coreControlPkg::controlWord_t ctrl,
   input  wire coreControlPkg::memBus_t      bus,
   output int                               errorCount,
   output int                               checkCount
);

   timeunit 1ns;
   timeprecision 100ps;

   import coreControlPkg::*;

   phase_t modelPhase;
   logic modelStore;
   flags_t modelFlags; // status register as the core should hold it
   controlWord_t expCtrl;
   memBus_t expBus;
   logic expStatusWe;

   function automatic logic conditionHolds(input branchCode_t cond, input flags_t st);
      case (cond)
         BNE: return !st.z;
         BE: return st.z;
         BLT: return st.n != st.v;
         BGE: return st.n == st.v;
         default: return 1'b1;
      endcase
   endfunction

   function automatic void expectOutputs(input phase_t ph, input logic store,
         input instrByte_t ins, input flags_t st, output controlWord_t c,
         output memBus_t b, output logic flagWrite);
      logic aluForm;
      aluForm = ins.opcode inside {ADD, ADDI, SUB, SUBI, CMP, CMPI, AND, OR, XOR, NOT, LSL, LSR};
      c = '0;
      c.immSel = ImmLong;
      flagWrite = 1'b0;
      b = memBus_t'(6'b000100); // bits are memEn nWE nOE nME enb ale
      case (ph)
         Fet1, Mem2: b = memBus_t'(6'b011101);
         Fet2: b = memBus_t'(6'b110000);
         Fet3: b = memBus_t'(6'b110010);
         Fet4: b = memBus_t'(6'b110100);
         Mem3: b = store ? memBus_t'(6'b011000) : memBus_t'(6'b110000);
         Mem4: b = store ? memBus_t'(6'b001000) : memBus_t'(6'b110010);
         Mem5: b = store ? memBus_t'(6'b000100) : memBus_t'(6'b110100);
         default: ;
      endcase
      case (ph)
         Fet1: c.pcEn = 1'b1;
         Fet4: c.irWe = 1'b1;
         Exe1: begin
            if (aluForm) begin
               c.pcEn = 1'b1;
               c.pcWe = 1'b1;
               flagWrite = 1'b1;
               c.regWe = !(ins.opcode inside {CMP, CMPI});
               case (ins.opcode)
                  ADD, ADDI: c.aluOp = FnAdd;
                  AND: c.aluOp = FnAnd;
                  OR: c.aluOp = FnOr;
                  XOR: c.aluOp = FnXor;
                  NOT: c.aluOp = FnNot;
                  LSL: c.aluOp = FnLsl;
                  LSR: c.aluOp = FnLsr;
                  default: c.aluOp = FnSub; // subtracts and both compares
               endcase
               if (ins.opcode inside {ADD, SUB, CMP, AND, OR, XOR}) c.op2Sel = Op2Rd2;
               if (ins.opcode inside {ADDI, SUBI, CMPI, LSL, LSR}) c.immSel = ImmShort;
            end else if (ins.opcode == LUI || ins.opcode == LLI) begin
               c.aluOp = (ins.opcode == LUI) ? FnLui : FnLli;
               c.regWe = 1'b1;
               c.pcWe = 1'b1;
            end else if (ins.opcode == LDW || ins.opcode == STW) begin
               c.aluOp = FnAdd;
               c.immSel = ImmShort;
               c.aluWe = 1'b1;
            end else if (ins.opcode == BRANCH) begin
               c.pcWe = 1'b1;
               if (ins.cond == RET) begin
                  c.lrEn = 1'b1;
                  c.pcSel = PcSysbus;
               end else if (ins.cond == JMP) begin
                  c.aluOp = FnAdd;
                  c.immSel = ImmShort;
                  c.pcSel = PcAluOut;
               end else begin
                  c.aluOp = FnAdd;
                  c.pcSel = conditionHolds(ins.cond, st) ? PcAluOut : Pc1;
                  c.lrWe = (ins.cond == BWL);
                  c.lrSel = (ins.cond == BWL) ? LrPc : LrSys;
               end
            end
         end
         Mem2: begin
            c.aluEn = 1'b1;
            c.aluOp = FnAdd;
            c.immSel = ImmShort;
         end
         Mem3: begin
            c.aluOp = FnPass;
            c.rs1Sel = Rs1Rd;
            c.aluWe = 1'b1;
            c.aluEn = 1'b1;
         end
         Mem4: c.aluEn = store;
         Mem5: begin
            c.pcWe = 1'b1;
            c.wdSel = store ? WdAlu : WdSys;
            c.regWe = !store; // load writeback
         end
         default: ;
      endcase
   endfunction

   always @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         modelPhase <= Fet1;
         modelStore <= 1'b0;
         modelFlags <= '0;
         errorCount = 0;
         checkCount = 0;
      end else begin
         expectOutputs(modelPhase, modelStore, instr, modelFlags, expCtrl, expBus, expStatusWe);
         checkCount++;
         if (ctrl !== expCtrl) begin
            errorCount++;
            $display("Error at %0t ns: %s in %s gives ctrl %h, expected %h", $time,
               instr.opcode.name(), modelPhase.name(), ctrl, expCtrl);
         end
         if (bus !== expBus) begin
            errorCount++;
            $display("Error at %0t ns: %s in %s gives bus %b, expected %b", $time,
               instr.opcode.name(), modelPhase.name(), bus, expBus);
         end
         if (expStatusWe) begin
            modelFlags <= flags;
         end
         case (modelPhase)
            Fet1: modelPhase <= Fet2;
            Fet2: modelPhase <= Fet3;
            Fet3: modelPhase <= Fet4;
            Fet4: modelPhase <= Exe1;
            Exe1: begin
               modelStore <= (instr.opcode == STW);
               modelPhase <= (instr.opcode inside {LDW, STW}) ? Mem2 : Fet1;
            end
            Mem2: modelPhase <= Mem3;
            Mem3: modelPhase <= Mem4;
            Mem4: modelPhase <= Mem5;
            default: modelPhase <= Fet1;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/controlUnit.sv ====
`default_nettype none

module controlUnit (
   input  wire                            Clock,
   input  wire                            nReset,
   input  wire coreControlPkg::instrByte_t instr,
   input  wire coreControlPkg::flags_t    flags,
   output coreControlPkg::controlWord_t   ctrl,
   output coreControlPkg::memBus_t        bus
);

   import coreControlPkg::*;

   seqState_t seq;
   logic statusWe;
   logic branchTaken;

   phaseSequencer sequencer (
      .Clock   (Clock),
      .nReset  (nReset),
      .opcode  (instr.opcode),
      .seq     (seq)
   );

   flagUnit flagRegs (
      .Clock       (Clock),
      .nReset      (nReset),
      .flags       (flags),
      .statusWe    (statusWe),
      .cond        (instr.cond),
      .branchTaken (branchTaken)
   );

   controlDecoder decoder (
      .instr       (instr),
      .seq         (seq),
      .branchTaken (branchTaken),
      .ctrl        (ctrl),
      .statusWe    (statusWe)
   );

   busCycleGen busGen (
      .seq (seq),
      .bus (bus)
   );

endmodule

`default_nettype wire

// ==== logic/busCycleGen.sv ====
`default_nettype none

module busCycleGen (
   input  wire coreControlPkg::seqState_t seq,
   output coreControlPkg::memBus_t        bus
);

   import coreControlPkg::*;

   always_comb begin
      bus = busIdle;
      case (seq.phase)
         Fet1, Mem2: begin
            bus.ale = 1'b1; // address latch cycle
            bus.nWE = 1'b1;
            bus.nOE = 1'b1;
         end
         Fet2: begin
            bus.nME = 1'b0;
            bus.nWE = 1'b1;
            bus.memEn = 1'b1;
         end
         Fet3: begin
            bus.nME = 1'b0;
            bus.memEn = 1'b1;
            bus.enb = 1'b1;
            bus.nWE = 1'b1;
         end
         Fet4: begin
            bus.nWE = 1'b1;
            bus.memEn = 1'b1;
         end
         Mem3: begin
            bus.nME = 1'b0;
            bus.nWE = 1'b1;
            if (seq.isStore) begin
               bus.nOE = 1'b1;
            end else begin
               bus.memEn = 1'b1;
            end
         end
         Mem4: begin
            bus.nME = 1'b0;
            if (seq.isStore) begin
               bus.nOE = 1'b1; // write strobe, nWE low
            end else begin
               bus.memEn = 1'b1;
               bus.enb = 1'b1;
               bus.nWE = 1'b1;
            end
         end
         Mem5: begin
            if (!seq.isStore) begin
               bus.nWE = 1'b1;
               bus.memEn = 1'b1;
            end
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/controlDecoder.sv ====
`default_nettype none

module controlDecoder (
   input  wire coreControlPkg::instrByte_t instr,
   input  wire coreControlPkg::seqState_t  seq,
   input  wire                             branchTaken,
   output coreControlPkg::controlWord_t    ctrl,
   output logic                            statusWe
);

   import coreControlPkg::*;

   function automatic aluFn_t aluFnOf(input opcode_t op);
      aluFn_t fn;
      case (op)
         ADD, ADDI: fn = FnAdd;
         SUB, SUBI, CMP, CMPI: fn = FnSub; // compare is a subtract without writeback
         AND: fn = FnAnd;
         OR: fn = FnOr;
         XOR: fn = FnXor;
         NOT: fn = FnNot;
         LSL: fn = FnLsl;
         LSR: fn = FnLsr;
         LUI: fn = FnLui;
         LLI: fn = FnLli;
         default: fn = FnNop;
      endcase
      return fn;
   endfunction

   always_comb begin
      ctrl = ctrlIdle;
      statusWe = 1'b0;
      case (seq.phase)
         Fet1: ctrl.pcEn = 1'b1; // pc out for the instruction address
         Fet4: ctrl.irWe = 1'b1;
         Exe1: begin
            case (instr.opcode)
               ADD, ADDI, SUB, SUBI, CMP, CMPI, AND, OR, XOR, NOT, LSL, LSR: begin
                  ctrl.aluOp = aluFnOf(instr.opcode);
                  ctrl.pcEn = 1'b1;
                  ctrl.pcWe = 1'b1;
                  ctrl.pcSel = Pc1;
                  ctrl.regWe = (instr.opcode != CMP) && (instr.opcode != CMPI);
                  statusWe = 1'b1;
                  case (instr.opcode)
                     ADD, SUB, CMP, AND, OR, XOR: ctrl.op2Sel = Op2Rd2;
                     ADDI, SUBI, CMPI, LSL, LSR: ctrl.immSel = ImmShort;
                     default: ; // NOT only uses operand one
                  endcase
               end
               LUI, LLI: begin
                  ctrl.aluOp = aluFnOf(instr.opcode);
                  ctrl.regWe = 1'b1;
                  ctrl.pcWe = 1'b1;
                  ctrl.pcSel = Pc1;
               end
               LDW, STW: begin
                  ctrl.aluOp = FnAdd; // effective address, held for Mem2
                  ctrl.immSel = ImmShort;
                  ctrl.aluWe = 1'b1;
               end
               BRANCH: begin
                  ctrl.pcWe = 1'b1;
                  case (instr.cond)
                     RET: begin
                        ctrl.lrEn = 1'b1;
                        ctrl.pcSel = PcSysbus;
                     end
                     JMP: begin
                        ctrl.aluOp = FnAdd;
                        ctrl.immSel = ImmShort;
                        ctrl.pcSel = PcAluOut;
                     end
                     default: begin
                        ctrl.aluOp = FnAdd; // pc relative target
                        ctrl.immSel = ImmLong;
                        if (branchTaken) begin
                           ctrl.pcSel = PcAluOut;
                        end else begin
                           ctrl.pcSel = Pc1;
                        end
                        if (instr.cond == BWL) begin
                           ctrl.lrWe = 1'b1;
                           ctrl.lrSel = LrPc;
                        end
                     end
                  endcase
               end
               default: ;
            endcase
         end
         Mem2: begin
            ctrl.aluEn = 1'b1; // address onto the system bus
            ctrl.aluOp = FnAdd;
            ctrl.immSel = ImmShort;
         end
         Mem3: begin
            ctrl.aluOp = FnPass;
            ctrl.rs1Sel = Rs1Rd;
            ctrl.aluWe = 1'b1;
            ctrl.aluEn = 1'b1;
         end
         Mem4: begin
            if (seq.isStore) begin
               ctrl.aluEn = 1'b1; // hold store data on the bus
            end
         end
         Mem5: begin
            ctrl.pcWe = 1'b1;
            ctrl.pcSel = Pc1;
            if (!seq.isStore) begin
               ctrl.wdSel = WdSys;
               ctrl.regWe = 1'b1;
            end
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/flagUnit.sv ====
`default_nettype none

module flagUnit (
   input  wire                           Clock,
   input  wire                           nReset,
   input  wire coreControlPkg::flags_t   flags,
   input  wire                           statusWe,
   input  wire coreControlPkg::branchCode_t cond,
   output logic                          branchTaken
);

   import coreControlPkg::*;

   flags_t statusReg;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         statusReg <= '0;
      end else if (statusWe) begin
         statusReg <= flags; // alu flags from the current exe cycle
      end
   end

   always_comb begin
      case (cond)
         BNE: branchTaken = !statusReg.z;
         BE:  branchTaken = statusReg.z;
         BLT: branchTaken = statusReg.n ^ statusReg.v; // signed less than
         BGE: branchTaken = !(statusReg.n ^ statusReg.v);
         default: branchTaken = 1'b1; // BR, BWL, RET, JMP
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/phaseSequencer.sv ====
`default_nettype none

module phaseSequencer (
   input  wire                       Clock,
   input  wire                       nReset,
   input  wire coreControlPkg::opcode_t opcode,
   output coreControlPkg::seqState_t seq
);

   import coreControlPkg::*;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         seq.phase <= Fet1;
         seq.isStore <= 1'b0;
      end else begin
         case (seq.phase)
            Fet1: seq.phase <= Fet2;
            Fet2: seq.phase <= Fet3;
            Fet3: seq.phase <= Fet4;
            Fet4: seq.phase <= Exe1;
            Exe1: begin
               seq.isStore <= (opcode == STW);
               if (opcode == LDW || opcode == STW) begin
                  seq.phase <= Mem2; // memory ops take four more cycles
               end else begin
                  seq.phase <= Fet1;
               end
            end
            Mem2: seq.phase <= Mem3;
            Mem3: seq.phase <= Mem4;
            Mem4: seq.phase <= Mem5;
            Mem5: seq.phase <= Fet1;
            default: seq.phase <= Fet1; // unused encodings recover to fetch
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/coreControlPkg.sv ====
`default_nettype none

package coreControlPkg;

   localparam int opcodeWidth = 5;
   localparam int condWidth = 3;

   typedef enum logic [opcodeWidth-1:0] {
      ADD    = 5'd0,
      ADDI   = 5'd1,
      SUB    = 5'd2,
      SUBI   = 5'd3,
      CMP    = 5'd4,
      CMPI   = 5'd5,
      AND    = 5'd6,
      OR     = 5'd7,
      XOR    = 5'd8,
      NOT    = 5'd9,
      LSL    = 5'd10,
      LSR    = 5'd11,
      LUI    = 5'd12,
      LLI    = 5'd13,
      LDW    = 5'd14,
      STW    = 5'd15,
      BRANCH = 5'd16
   } opcode_t;

   typedef enum logic [condWidth-1:0] {
      BR  = 3'd0,
      BNE = 3'd1,
      BE  = 3'd2,
      BLT = 3'd3,
      BGE = 3'd4,
      BWL = 3'd5, // branch with link
      RET = 3'd6,
      JMP = 3'd7
   } branchCode_t;

   typedef struct packed {
      opcode_t     opcode;
      branchCode_t cond;
   } instrByte_t;

   typedef struct packed {
      logic z;
      logic n;
      logic v;
   } flags_t;

   typedef enum logic [3:0] {
      Fet1, Fet2, Fet3, Fet4,
      Exe1, Mem2, Mem3, Mem4, Mem5
   } phase_t;

   typedef struct packed {
      phase_t phase;
      logic   isStore; // valid from Mem2 to Mem5
   } seqState_t;

   typedef enum logic [3:0] {
      FnNop, FnAdd, FnSub, FnAnd, FnOr, FnXor,
      FnNot, FnLsl, FnLsr, FnLui, FnLli, FnPass
   } aluFn_t;

   typedef enum logic {Op1Rd1, Op1Pc} op1Sel_t;
   typedef enum logic {Op2Imm, Op2Rd2} op2Sel_t;
   typedef enum logic {ImmShort, ImmLong} immSel_t;
   typedef enum logic {WdAlu, WdSys} wdSel_t;
   typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus} pcSel_t;
   typedef enum logic {LrSys, LrPc} lrSel_t;
   typedef enum logic {Rs1Ra, Rs1Rd} rs1Sel_t;

   typedef struct packed {
      aluFn_t   aluOp;
      op1Sel_t  op1Sel;
      op2Sel_t  op2Sel;
      immSel_t  immSel;
      wdSel_t   wdSel;
      pcSel_t   pcSel;
      lrSel_t   lrSel;
      rs1Sel_t  rs1Sel;
      logic     aluEn;
      logic     aluWe;
      logic     lrEn;
      logic     lrWe;
      logic     pcEn; // drives PC onto the system bus
      logic     pcWe;
      logic     irWe;
      logic     regWe;
   } controlWord_t;

   typedef struct packed {
      logic memEn; // pad direction
      logic nWE;
      logic nOE;
      logic nME;
      logic enb;
      logic ale;
   } memBus_t;

   localparam controlWord_t ctrlIdle = '{
      aluOp: FnNop, op1Sel: Op1Rd1, op2Sel: Op2Imm, immSel: ImmLong,
      wdSel: WdAlu, pcSel: Pc1, lrSel: LrSys, rs1Sel: Rs1Ra,
      aluEn: 1'b0, aluWe: 1'b0, lrEn: 1'b0, lrWe: 1'b0,
      pcEn: 1'b0, pcWe: 1'b0, irWe: 1'b0, regWe: 1'b0
   };

   localparam memBus_t busIdle = '{
      memEn: 1'b0, nWE: 1'b0, nOE: 1'b0, nME: 1'b1, enb: 1'b0, ale: 1'b0
   };

endpackage

`default_nettype wire
